//--- core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Datapath and register file shape
`define CORE_DATA_WIDTH 32
`define CORE_REG_COUNT 16
`define CORE_OPCODE_WIDTH 8 // Low byte of the instruction word

// Byte strides
`define CORE_INSTR_BYTES 4 // One instruction or constant word
`define CORE_STACK_STEP 4  // Stack grows upward by one word

// Values after reset
`define CORE_RESET_POINTER 32'h0000_0000
`define CORE_REG_RESET 32'h0000_0000

`endif

//--- memPkg.sv
`default_nettype none
`include "core_settings.svh"

package memPkg;

  typedef logic [`CORE_DATA_WIDTH-1:0] wordT; // Bus and register word
  typedef logic [`CORE_DATA_WIDTH-1:0] addrT; // Byte address

  // Purpose of one bus access
  typedef enum logic [1:0] {
    instrFetch,
    constFetch, // Word after the instruction
    dataAccess
  } accessT;

  // Request on the outside bus
  typedef struct packed {
    addrT addr;
    wordT wdata; // Don't care on reads
    logic write;
  } memReqT;

endpackage

`default_nettype wire

//--- isaPkg.sv
`default_nettype none
`include "core_settings.svh"

package isaPkg;

  localparam int RegBits = $clog2(`CORE_REG_COUNT);
  typedef logic [RegBits-1:0] regIndexT;

  localparam regIndexT StackReg = 0; // r0 holds the stack pointer
  localparam regIndexT FlagReg = 1;  // Compare results land here

  // Bit 7 set means a constant word follows
  typedef enum logic [`CORE_OPCODE_WIDTH-1:0] {
    opHalt     = 8'h00,
    opMovRR    = 8'h01, // rd = rs
    opAddRRR   = 8'h02,
    opSubRRR   = 8'h03,
    opIncR     = 8'h04,
    opDecR     = 8'h05,
    opShlRRR   = 8'h06,
    opShrRRR   = 8'h07,
    opNegRR    = 8'h08, // rd = -rs
    opCmpRR    = 8'h09, // Flags from rd vs rs
    opCmpERRR  = 8'h0A, // rd = (rs == rt)
    opCmpNeRRR = 8'h0B,
    opCmpLtRRR = 8'h0C,
    opCmpGtRRR = 8'h0D,
    opLdRR     = 8'h0E, // rd = [rs]
    opPushR    = 8'h10,
    opPopR     = 8'h11,
    opCallR    = 8'h12, // Target in rd
    opRet      = 8'h13,
    opMovRC    = 8'h80,
    opAddRRC   = 8'h81,
    opSubRRC   = 8'h82,
    opCmpRC    = 8'h83, // Flags from rd vs constant
    opJmpC     = 8'h84,
    opJeC      = 8'h85,
    opJneC     = 8'h86,
    opJzRC     = 8'h87, // Tests rt
    opJnzRC    = 8'h88,
    opLdRC     = 8'h89, // rd = [c]
    opLdRRo    = 8'h8A, // rd = [rs + c]
    opStCR     = 8'h8B, // [c] = rs
    opStRoR    = 8'h8C  // [rd + c] = rs
  } opcodeT;

  typedef enum logic [2:0] {
    memNone,
    memLoad,
    memStore,
    memPush,
    memPop,
    memCall,
    memRet
  } memKindT;

  typedef struct packed {
    opcodeT   opcode;
    regIndexT rd;
    regIndexT rs;
    regIndexT rt;
    logic     hasConst;
    memKindT  memKind;
    logic     isControl; // Sets the pointer itself
  } decodedInstrT;

  typedef struct packed {
    logic         en;
    regIndexT     idx;
    memPkg::wordT data;
  } regWriteT;

endpackage

`default_nettype wire

//--- instrDecode.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_settings.svh"

module instrDecode (
  input  wire memPkg::wordT         instrWord,
  output      isaPkg::decodedInstrT decoded
);

  localparam int FieldBits = 8; // Each register field is one byte
  localparam int RegBits = $bits(isaPkg::regIndexT);

  isaPkg::opcodeT  op;
  isaPkg::memKindT kind;
  logic            isCtl;

  always_comb begin
    op    = isaPkg::opcodeT'(instrWord[`CORE_OPCODE_WIDTH-1:0]);
    kind  = isaPkg::memNone;
    isCtl = 1'b0;
    case (op)
      isaPkg::opMovRR, isaPkg::opAddRRR, isaPkg::opSubRRR, isaPkg::opIncR,
      isaPkg::opDecR, isaPkg::opShlRRR, isaPkg::opShrRRR, isaPkg::opNegRR,
      isaPkg::opCmpRR, isaPkg::opCmpERRR, isaPkg::opCmpNeRRR, isaPkg::opCmpLtRRR,
      isaPkg::opCmpGtRRR, isaPkg::opMovRC, isaPkg::opAddRRC, isaPkg::opSubRRC,
      isaPkg::opCmpRC: ; // Register only
      isaPkg::opLdRR, isaPkg::opLdRC, isaPkg::opLdRRo: kind = isaPkg::memLoad;
      isaPkg::opStCR, isaPkg::opStRoR: kind = isaPkg::memStore;
      isaPkg::opPushR: kind = isaPkg::memPush;
      isaPkg::opPopR: kind = isaPkg::memPop;
      isaPkg::opCallR: begin
        kind  = isaPkg::memCall;
        isCtl = 1'b1;
      end
      isaPkg::opRet: begin
        kind  = isaPkg::memRet;
        isCtl = 1'b1;
      end
      isaPkg::opJmpC, isaPkg::opJeC, isaPkg::opJneC, isaPkg::opJzRC,
      isaPkg::opJnzRC, isaPkg::opHalt: isCtl = 1'b1;
      default: begin
        op    = isaPkg::opHalt; // Unknown code stops the core
        isCtl = 1'b1;
      end
    endcase
  end

  always_comb begin
    decoded.opcode    = op;
    decoded.rd        = instrWord[FieldBits +: RegBits];
    decoded.rs        = instrWord[2*FieldBits +: RegBits];
    decoded.rt        = instrWord[3*FieldBits +: RegBits];
    decoded.hasConst  = op[`CORE_OPCODE_WIDTH-1]; // Clear for remapped halt
    decoded.memKind   = kind;
    decoded.isControl = isCtl;
  end

endmodule

`default_nettype wire

//--- regFile.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_settings.svh"

module regFile (
  input  wire logic                 clk,
  input  wire logic                 reset,
  input  wire isaPkg::decodedInstrT decoded,
  output      memPkg::wordT         readA, // rd
  output      memPkg::wordT         readB, // rs
  output      memPkg::wordT         readC, // rt
  output      memPkg::wordT         sp,
  output      memPkg::wordT         flags,
  input  wire isaPkg::regWriteT     regWrite,
  input  wire memPkg::wordT         spNext,
  input  wire logic                 commit
);

  memPkg::wordT regs [`CORE_REG_COUNT];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < `CORE_REG_COUNT; i++) begin
        regs[i] <= `CORE_REG_RESET;
      end
    end else if (commit) begin
      if (regWrite.en) begin
        regs[regWrite.idx] <= regWrite.data;
      end
      regs[isaPkg::StackReg] <= spNext; // Later write, so sp wins on r0
    end
  end

  // Operands settle one cycle after decode
  always_ff @(posedge clk) begin
    readA <= regs[decoded.rd];
    readB <= regs[decoded.rs];
    readC <= regs[decoded.rt];
  end

  assign sp    = regs[isaPkg::StackReg];
  assign flags = regs[isaPkg::FlagReg];

endmodule

`default_nettype wire

//--- execUnit.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_settings.svh"

module execUnit (
  input  wire isaPkg::decodedInstrT decoded,
  input  wire memPkg::wordT         readA,
  input  wire memPkg::wordT         readB,
  input  wire memPkg::wordT         readC,
  input  wire memPkg::wordT         constWord,
  input  wire memPkg::wordT         loadWord,
  input  wire memPkg::wordT         sp,
  input  wire memPkg::wordT         flags,
  input  wire memPkg::addrT         ipointer,
  output      isaPkg::regWriteT     regWrite,
  output      memPkg::wordT         spNext,
  output      memPkg::addrT         nextPointer,
  output      logic                 haltReq
);

  memPkg::wordT arithB;     // rt or constant
  memPkg::wordT cmpWith;    // rs or constant
  memPkg::addrT seqPointer; // Fall-through address

  // Unsigned {greater, less, equal}
  function automatic logic [2:0] compare(memPkg::wordT a, memPkg::wordT b);
    return {a > b, a < b, a == b};
  endfunction

  assign arithB = decoded.hasConst ? constWord : readC;
  assign cmpWith = decoded.hasConst ? constWord : readB;
  assign seqPointer = ipointer + (decoded.hasConst ? 2 * `CORE_INSTR_BYTES : `CORE_INSTR_BYTES);

  always_comb begin
    regWrite.en   = 1'b1;
    regWrite.idx  = decoded.rd;
    regWrite.data = '0;
    spNext        = sp;
    nextPointer   = decoded.isControl ? ipointer : seqPointer; // Halt holds
    haltReq       = 1'b0;
    case (decoded.opcode)
      isaPkg::opMovRR: regWrite.data = readB;
      isaPkg::opMovRC: regWrite.data = constWord;
      isaPkg::opAddRRR, isaPkg::opAddRRC: regWrite.data = readB + arithB;
      isaPkg::opSubRRR, isaPkg::opSubRRC: regWrite.data = readB - arithB;
      isaPkg::opIncR: regWrite.data = readA + 1'b1;
      isaPkg::opDecR: regWrite.data = readA - 1'b1;
      isaPkg::opShlRRR: regWrite.data = readB << readC;
      isaPkg::opShrRRR: regWrite.data = readB >> readC;
      isaPkg::opNegRR: regWrite.data = -readB;
      isaPkg::opCmpRR, isaPkg::opCmpRC: begin
        regWrite.idx  = isaPkg::FlagReg;
        regWrite.data = {flags[`CORE_DATA_WIDTH-1:3], compare(readA, cmpWith)}; // Upper bits kept
      end
      isaPkg::opCmpERRR: regWrite.data = memPkg::wordT'(readB == readC);
      isaPkg::opCmpNeRRR: regWrite.data = memPkg::wordT'(readB != readC);
      isaPkg::opCmpLtRRR: regWrite.data = memPkg::wordT'(readB < readC);
      isaPkg::opCmpGtRRR: regWrite.data = memPkg::wordT'(readB > readC);
      isaPkg::opLdRR, isaPkg::opLdRC, isaPkg::opLdRRo: regWrite.data = loadWord;
      isaPkg::opStCR, isaPkg::opStRoR: regWrite.en = 1'b0; // Bus did the work
      isaPkg::opPopR: begin
        regWrite.data = loadWord;
        spNext        = sp - `CORE_STACK_STEP;
      end
      isaPkg::opPushR: begin
        regWrite.en = 1'b0;
        spNext      = sp + `CORE_STACK_STEP;
      end
      isaPkg::opCallR: begin
        regWrite.en = 1'b0;
        spNext      = sp + `CORE_STACK_STEP; // Return slot pushed
        nextPointer = readA;
      end
      isaPkg::opRet: begin
        regWrite.en = 1'b0;
        spNext      = sp - `CORE_STACK_STEP;
        nextPointer = loadWord + `CORE_INSTR_BYTES; // Skip the call itself
      end
      isaPkg::opJmpC: begin
        regWrite.en = 1'b0;
        nextPointer = constWord;
      end
      isaPkg::opJeC: begin
        regWrite.en = 1'b0;
        nextPointer = flags[0] ? constWord : seqPointer;
      end
      isaPkg::opJneC: begin
        regWrite.en = 1'b0;
        nextPointer = flags[0] ? seqPointer : constWord;
      end
      isaPkg::opJzRC: begin
        regWrite.en = 1'b0;
        nextPointer = (readC == '0) ? constWord : seqPointer;
      end
      isaPkg::opJnzRC: begin
        regWrite.en = 1'b0;
        nextPointer = (readC != '0) ? constWord : seqPointer;
      end
      default: begin
        regWrite.en = 1'b0; // Halt
        haltReq     = 1'b1;
      end
    endcase
    // Plain write to r0 moves sp as well
    if (regWrite.en && regWrite.idx == isaPkg::StackReg &&
        decoded.memKind != isaPkg::memPop) begin
      spNext = regWrite.data;
    end
  end

endmodule

`default_nettype wire

//--- memAccess.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_settings.svh"

module memAccess (
  input  wire logic                 clk,
  input  wire logic                 reset,
  input  wire logic                 accessStart,
  input  wire memPkg::accessT       accessKind,
  input  wire isaPkg::decodedInstrT decoded,
  input  wire memPkg::wordT         readA,
  input  wire memPkg::wordT         readB,
  input  wire memPkg::wordT         constWord,
  input  wire memPkg::wordT         sp,
  input  wire memPkg::addrT         ipointer,
  output      logic                 accessDone,
  output      memPkg::wordT         accessData,
  output      memPkg::memReqT       memReq,
  output      logic                 memReqValid,
  input  wire logic                 memReqReady,
  input  wire logic                 memRspValid,
  input  wire memPkg::wordT         memRspData
);

  typedef enum logic [1:0] {
    idle,
    request,  // Valid high, waiting for ready
    response
  } stateT;

  stateT          state;
  memPkg::memReqT reqNext;

  always_comb begin
    reqNext = '{addr: ipointer, wdata: '0, write: 1'b0}; // Instruction fetch
    case (accessKind)
      memPkg::constFetch: reqNext.addr = ipointer + `CORE_INSTR_BYTES;
      memPkg::dataAccess: begin
        case (decoded.memKind)
          isaPkg::memLoad: begin
            if (decoded.opcode == isaPkg::opLdRR) begin
              reqNext.addr = readB;
            end else if (decoded.opcode == isaPkg::opLdRC) begin
              reqNext.addr = constWord;
            end else begin
              reqNext.addr = readB + constWord; // Base plus offset
            end
          end
          isaPkg::memStore: begin
            reqNext.addr  = (decoded.opcode == isaPkg::opStCR) ? constWord : readA + constWord;
            reqNext.wdata = readB;
            reqNext.write = 1'b1;
          end
          isaPkg::memPush, isaPkg::memCall: begin
            reqNext.addr  = sp;
            reqNext.wdata = (decoded.memKind == isaPkg::memCall) ? ipointer : readA;
            reqNext.write = 1'b1;
          end
          default: reqNext.addr = sp - `CORE_STACK_STEP; // Pop and return
        endcase
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state      <= idle;
      accessDone <= 1'b0;
    end else begin
      accessDone <= 1'b0;
      case (state)
        idle: if (accessStart) state <= request;
        request: if (memReqReady) state <= response;
        response: begin
          if (memRspValid) begin
            state      <= idle;
            accessDone <= 1'b1; // One cycle after the response
          end
        end
        default: state <= idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == idle && accessStart) begin
      memReq <= reqNext; // Held until the transfer
    end
    if (state == response && memRspValid) begin
      accessData <= memRspData;
    end
  end

  assign memReqValid = (state == request);

endmodule

`default_nettype wire

//--- coreSequencer.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_settings.svh"

module coreSequencer (
  input  wire logic                 clk,
  input  wire logic                 reset,
  input  wire isaPkg::decodedInstrT decoded,
  output      logic                 accessStart,
  output      memPkg::accessT       accessKind,
  input  wire logic                 accessDone,
  input  wire memPkg::wordT         accessData,
  output      memPkg::wordT         instrWord,
  output      memPkg::wordT         constWord,
  output      memPkg::wordT         loadWord,
  output      memPkg::addrT         ipointer,
  input  wire memPkg::addrT         nextPointer,
  input  wire logic                 haltReq,
  output      logic                 commit,
  output      logic                 halted
);

  typedef enum logic [3:0] {
    fetch,
    fetchWait,
    decode,
    operand,    // Register reads valid here
    constFetch,
    constWait,
    dataAccess,
    dataWait,
    execute,
    halt
  } stateT;

  stateT state;
  stateT stateNext;
  logic  needData;

  assign needData = (decoded.memKind != isaPkg::memNone);

  always_comb begin
    stateNext = state;
    case (state)
      fetch: stateNext = fetchWait;
      fetchWait: if (accessDone) stateNext = decode;
      decode: stateNext = operand;
      operand: begin
        if (decoded.hasConst) begin
          stateNext = constFetch;
        end else begin
          stateNext = needData ? dataAccess : execute;
        end
      end
      constFetch: stateNext = constWait;
      constWait: if (accessDone) stateNext = needData ? dataAccess : execute;
      dataAccess: stateNext = dataWait;
      dataWait: if (accessDone) stateNext = execute;
      execute: stateNext = haltReq ? halt : fetch;
      default: stateNext = halt; // Only reset leaves
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state    <= fetch;
      ipointer <= `CORE_RESET_POINTER;
    end else begin
      state <= stateNext;
      if (commit) begin
        ipointer <= nextPointer;
      end
    end
  end

  // Words captured from the bus
  always_ff @(posedge clk) begin
    if (state == fetchWait && accessDone) instrWord <= accessData;
    if (state == constWait && accessDone) constWord <= accessData;
    if (state == dataWait && accessDone) loadWord <= accessData;
  end

  always_comb begin
    case (state)
      constFetch: accessKind = memPkg::constFetch;
      dataAccess: accessKind = memPkg::dataAccess;
      default: accessKind = memPkg::instrFetch;
    endcase
  end

  assign accessStart = (state == fetch) || (state == constFetch) || (state == dataAccess);
  assign commit      = (state == execute);
  assign halted      = (state == halt);

endmodule

`default_nettype wire

//--- coreTop.sv
`timescale 1ns/1ps
`default_nettype none

module coreTop (
  input  wire logic           clk,
  input  wire logic           reset,
  output      memPkg::memReqT memReq,
  output      logic           memReqValid,
  input  wire logic           memReqReady,
  input  wire logic           memRspValid,
  input  wire memPkg::wordT   memRspData,
  output      logic           halted
);

  isaPkg::decodedInstrT decoded;
  isaPkg::regWriteT     regWrite;
  memPkg::accessT       accessKind;
  logic                 accessStart;
  logic                 accessDone;
  logic                 commit;
  logic                 haltReq;
  memPkg::wordT         accessData;
  memPkg::wordT         instrWord;
  memPkg::wordT         constWord;
  memPkg::wordT         loadWord;
  memPkg::wordT         readA;
  memPkg::wordT         readB;
  memPkg::wordT         readC;
  memPkg::wordT         sp;
  memPkg::wordT         flags;
  memPkg::wordT         spNext;
  memPkg::addrT         ipointer;
  memPkg::addrT         nextPointer;

  coreSequencer u_sequencer (
    .clk(clk), .reset(reset), .decoded(decoded),
    .accessStart(accessStart), .accessKind(accessKind),
    .accessDone(accessDone), .accessData(accessData),
    .instrWord(instrWord), .constWord(constWord), .loadWord(loadWord),
    .ipointer(ipointer), .nextPointer(nextPointer), .haltReq(haltReq),
    .commit(commit), .halted(halted)
  );

  instrDecode u_decode (.instrWord(instrWord), .decoded(decoded));

  regFile u_regs (
    .clk(clk), .reset(reset), .decoded(decoded),
    .readA(readA), .readB(readB), .readC(readC), .sp(sp), .flags(flags),
    .regWrite(regWrite), .spNext(spNext), .commit(commit)
  );

  execUnit u_exec (
    .decoded(decoded), .readA(readA), .readB(readB), .readC(readC),
    .constWord(constWord), .loadWord(loadWord), .sp(sp), .flags(flags),
    .ipointer(ipointer), .regWrite(regWrite), .spNext(spNext),
    .nextPointer(nextPointer), .haltReq(haltReq)
  );

  // Only bus master in the core
  memAccess u_mem (
    .clk(clk), .reset(reset), .accessStart(accessStart), .accessKind(accessKind),
    .decoded(decoded), .readA(readA), .readB(readB), .constWord(constWord),
    .sp(sp), .ipointer(ipointer), .accessDone(accessDone), .accessData(accessData),
    .memReq(memReq), .memReqValid(memReqValid), .memReqReady(memReqReady),
    .memRspValid(memRspValid), .memRspData(memRspData)
  );

endmodule

`default_nettype wire

//--- core_assertions.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_settings.svh"

module coreAssertions (
  input wire logic           clk,
  input wire logic           reset,
  input wire memPkg::memReqT memReq,
  input wire logic           memReqValid,
  input wire logic           memReqReady,
  input wire logic           memRspValid,
  input wire logic           halted
);

  int   failCount = 0; // Read by the testbench after each program
  logic outstanding;    // Transfer done, response not yet seen

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      outstanding <= 1'b0;
    end else if (memReqValid && memReqReady) begin
      outstanding <= 1'b1;
    end else if (memRspValid) begin
      outstanding <= 1'b0;
    end
  end

  // Request held until ready
  reqStable: assert property (@(posedge clk) disable iff (reset)
    memReqValid && !memReqReady |=> memReqValid && $stable(memReq))
    else begin
      failCount++;
      $error("memReq changed or valid dropped before ready");
    end

  haltQuiet: assert property (@(posedge clk) disable iff (reset)
    halted |-> !memReqValid)
    else begin
      failCount++;
      $error("request issued while halted");
    end

  // One request in flight at most
  singleOutstanding: assert property (@(posedge clk) disable iff (reset)
    outstanding |-> !memReqValid)
    else begin
      failCount++;
      $error("new request while a response is outstanding");
    end

endmodule

`default_nettype wire

//--- tbMemory.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_settings.svh"

module tbMemory #(
  parameter int Words = 1024
) (
  input  wire logic           clk,
  input  wire logic           reset,
  input  wire memPkg::memReqT memReq,
  input  wire logic           memReqValid,
  output      logic           memReqReady,
  output      logic           memRspValid,
  output      memPkg::wordT   memRspData,
  input  wire logic           stallEnable, // Random waits on ready and response
  input  wire logic [1:0]     stallDraw    // Fresh LFSR bits each cycle
);

  localparam int AddrHi = $clog2(Words) + 1; // Word index from byte address

  memPkg::wordT mem [Words];
  memPkg::wordT readData;          // Held for the response
  memPkg::wordT rspData = '0;
  logic         readyReg = 1'b0;
  logic         rspValidReg = 1'b0;
  logic         pending = 1'b0;    // Transfer taken, response owed
  logic [1:0]   readyWait = '0;
  logic [1:0]   rspWait = '0;

  assign memReqReady = readyReg;
  assign memRspValid = rspValidReg;
  assign memRspData  = rspData;

  always @(posedge clk or posedge reset) begin
    if (reset) begin
      readyReg    <= 1'b0;
      rspValidReg <= 1'b0;
      pending     <= 1'b0;
      readyWait   <= '0;
      rspWait     <= '0;
    end else begin
      rspValidReg <= 1'b0;
      if (memReqValid && readyReg) begin
        readyReg <= 1'b0; // Transfer on this edge
        pending  <= 1'b1;
        rspWait  <= stallEnable ? stallDraw : 2'd0;
        if (memReq.write) begin
          mem[memReq.addr[AddrHi:2]] = memReq.wdata;
        end else begin
          readData <= mem[memReq.addr[AddrHi:2]];
        end
      end else if (memReqValid && !pending) begin
        if (readyWait == 2'd0) readyReg <= 1'b1;
        else readyWait <= readyWait - 2'd1; // Stall ready
      end
      if (pending) begin
        if (rspWait == 2'd0) begin
          rspValidReg <= 1'b1; // Stores answer too
          rspData     <= readData;
          pending     <= 1'b0;
          readyWait   <= stallEnable ? stallDraw : 2'd0;
        end else begin
          rspWait <= rspWait - 2'd1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- tbCore.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_settings.svh"

module tbClock (
  output logic clk
);

  initial clk = 1'b0;
  always #2 clk = ~clk; // 4 ns period

endmodule

module tbCore;

  // About 60 instructions, each up to 3 accesses of 12 cycles under stalls, with margin
  localparam int HaltLimit = 4000;

  logic           clk;
  logic           reset = 1'b1;
  logic           stallEnable = 1'b0;
  logic [1:0]     stallDraw = 2'b00;
  logic [31:0]    rngState = 32'hcaf4_1e42;
  logic           bitLo;
  logic           bitHi;
  memPkg::memReqT memReq;
  logic           memReqValid;
  logic           memReqReady;
  logic           memRspValid;
  memPkg::wordT   memRspData;
  logic           halted;
  memPkg::addrT   pc;       // Program assembly pointer
  string          testName;

  tbClock u_clk (.clk(clk));

  tbMemory u_mem (
    .clk(clk), .reset(reset), .memReq(memReq), .memReqValid(memReqValid),
    .memReqReady(memReqReady), .memRspValid(memRspValid), .memRspData(memRspData),
    .stallEnable(stallEnable), .stallDraw(stallDraw)
  );

  coreTop u_dut (
    .clk(clk), .reset(reset), .memReq(memReq), .memReqValid(memReqValid),
    .memReqReady(memReqReady), .memRspValid(memRspValid), .memRspData(memRspData),
    .halted(halted)
  );

  bind coreTop coreAssertions u_asserts (
    .clk(clk), .reset(reset), .memReq(memReq), .memReqValid(memReqValid),
    .memReqReady(memReqReady), .memRspValid(memRspValid), .halted(halted)
  );

  function automatic logic [31:0] lfsrStep(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // Two bits per cycle, one step each
  always @(posedge clk) begin
    rngState = lfsrStep(rngState);
    bitLo    = rngState[0];
    rngState = lfsrStep(rngState);
    bitHi    = rngState[0];
    stallDraw <= {bitHi, bitLo};
  end

  task automatic stopRun(string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check(string what, memPkg::wordT expected, memPkg::wordT actual);
    if (actual !== expected) begin
      $display("ERROR %s %s: expected %h actual %h", testName, what, expected, actual);
      stopRun("value mismatch");
    end
  endtask

  // Word layout {rt, rs, rd, opcode}
  function automatic memPkg::wordT enc(isaPkg::opcodeT op, int rd, int rs, int rt);
    return {rt[7:0], rs[7:0], rd[7:0], op};
  endfunction

  function automatic memPkg::wordT readWord(memPkg::addrT addr);
    return u_mem.mem[addr[11:2]];
  endfunction

  task automatic pokeWord(memPkg::addrT addr, memPkg::wordT data);
    u_mem.mem[addr[11:2]] = data;
  endtask

  task automatic put(memPkg::wordT w);
    pokeWord(pc, w);
    pc = pc + 4;
  endtask

  task automatic emitMove(int rd, memPkg::wordT c);
    put(enc(isaPkg::opMovRC, rd, 0, 0));
    put(c);
  endtask

  task automatic emitStore(memPkg::addrT addr, int rs);
    put(enc(isaPkg::opStCR, 0, rs, 0));
    put(addr);
  endtask

  // Taken path stores 1 at addr, 32 bytes in all
  task automatic emitBranch(isaPkg::opcodeT op, memPkg::addrT addr);
    memPkg::addrT base;
    base = pc;
    put(enc(op, 0, 0, 0));
    put(base + 16);
    put(enc(isaPkg::opJmpC, 0, 0, 0));
    put(base + 32); // Skip the taken path
    emitMove(5, 1);
    emitStore(addr, 5);
  endtask

  task automatic beginProgram(string name);
    testName = stallEnable ? {name, "/stall"} : name;
    for (int i = 0; i < 1024; i++) begin
      u_mem.mem[i] = '0; // Zero word is halt
    end
    pc = '0;
  endtask

  task automatic runProgram();
    int cycles;
    cycles = 0;
    @(posedge clk);
    reset <= 1'b1;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    while (!halted) begin
      if (cycles >= HaltLimit) stopRun("timeout: core did not halt");
      else begin
        cycles++;
        @(negedge clk);
      end
    end
    check("assertion failures", 0, memPkg::wordT'(u_dut.u_asserts.failCount));
  endtask

  task automatic arithTest();
    memPkg::wordT a;
    memPkg::wordT b;
    memPkg::wordT s;
    a = 100;
    b = 32'h7fff_fff0;
    s = 3;
    beginProgram("arith");
    emitMove(2, a);
    emitMove(3, b);
    put(enc(isaPkg::opAddRRR, 4, 2, 3));
    put(enc(isaPkg::opSubRRC, 5, 2, 0));
    put(200);
    emitMove(6, s);
    put(enc(isaPkg::opShlRRR, 7, 3, 6));
    put(enc(isaPkg::opShrRRR, 8, 5, 6));
    put(enc(isaPkg::opNegRR, 9, 2, 0));
    put(enc(isaPkg::opIncR, 2, 0, 0));
    put(enc(isaPkg::opDecR, 6, 0, 0));
    put(enc(isaPkg::opAddRRC, 10, 3, 0));
    put(32'h20);
    emitStore(32'h200, 4);
    emitStore(32'h204, 5);
    emitStore(32'h208, 7);
    emitStore(32'h20c, 8);
    emitStore(32'h210, 9);
    emitStore(32'h214, 2);
    emitStore(32'h218, 6);
    emitStore(32'h21c, 10);
    put(enc(isaPkg::opHalt, 0, 0, 0));
    runProgram();
    check("add", a + b, readWord(32'h200));
    check("sub", a - 200, readWord(32'h204));
    check("shl", b << s, readWord(32'h208));
    check("shr", (a - 200) >> s, readWord(32'h20c));
    check("neg", -a, readWord(32'h210));
    check("inc", a + 1, readWord(32'h214));
    check("dec", s - 1, readWord(32'h218));
    check("add const", b + 32'h20, readWord(32'h21c));
  endtask

  task automatic branchTest();
    memPkg::addrT loopTop;
    beginProgram("branch");
    emitMove(2, 5);
    emitMove(3, 0);
    loopTop = pc;
    put(enc(isaPkg::opIncR, 3, 0, 0)); // Counts iterations
    put(enc(isaPkg::opDecR, 2, 0, 0));
    put(enc(isaPkg::opJnzRC, 0, 0, 2));
    put(loopTop);
    emitStore(32'h200, 3);
    emitMove(4, 7);
    put(enc(isaPkg::opCmpRC, 4, 0, 0));
    put(7);
    emitBranch(isaPkg::opJeC, 32'h204);
    put(enc(isaPkg::opCmpRC, 4, 0, 0));
    put(9);
    emitBranch(isaPkg::opJeC, 32'h208);
    emitBranch(isaPkg::opJneC, 32'h20c);
    put(enc(isaPkg::opCmpLtRRR, 7, 2, 4));
    put(enc(isaPkg::opCmpGtRRR, 8, 2, 4));
    emitStore(32'h210, 7);
    emitStore(32'h214, 8);
    emitStore(32'h218, 1); // Flag register
    put(enc(isaPkg::opHalt, 0, 0, 0));
    runProgram();
    check("loop count", 5, readWord(32'h200));
    check("je taken", 1, readWord(32'h204));
    check("je not taken", 0, readWord(32'h208));
    check("jne taken", 1, readWord(32'h20c));
    check("cmp less", 1, readWord(32'h210));
    check("cmp greater", 0, readWord(32'h214));
    check("flags 7 vs 9", 32'h2, readWord(32'h218));
  endtask

  task automatic memoryTest();
    beginProgram("memory");
    pokeWord(32'h300, 32'ha5a5_0001);
    pokeWord(32'h304, 32'h5a5a_0002);
    pokeWord(32'h308, 32'h0f0f_0003);
    put(enc(isaPkg::opLdRC, 2, 0, 0));
    put(32'h300);
    emitMove(3, 32'h304);
    put(enc(isaPkg::opLdRR, 4, 3, 0));
    emitMove(5, 32'h300);
    put(enc(isaPkg::opLdRRo, 6, 5, 0));
    put(8);
    emitStore(32'h200, 2);
    emitMove(7, 32'h200);
    put(enc(isaPkg::opStRoR, 7, 4, 0)); // Base plus offset
    put(4);
    put(enc(isaPkg::opStRoR, 7, 6, 0));
    put(8);
    put(enc(isaPkg::opHalt, 0, 0, 0));
    runProgram();
    check("absolute", 32'ha5a5_0001, readWord(32'h200));
    check("register", 32'h5a5a_0002, readWord(32'h204));
    check("offset", 32'h0f0f_0003, readWord(32'h208));
  endtask

  task automatic stackTest();
    beginProgram("stack");
    emitMove(0, 32'h380); // Stack base
    emitMove(2, 11);
    emitMove(3, 22);
    emitMove(4, 33);
    put(enc(isaPkg::opPushR, 2, 0, 0));
    put(enc(isaPkg::opPushR, 3, 0, 0));
    put(enc(isaPkg::opPushR, 4, 0, 0));
    put(enc(isaPkg::opPopR, 5, 0, 0));
    put(enc(isaPkg::opPopR, 6, 0, 0));
    put(enc(isaPkg::opPopR, 7, 0, 0));
    emitStore(32'h200, 5);
    emitStore(32'h204, 6);
    emitStore(32'h208, 7);
    emitMove(8, 32'h100);
    put(enc(isaPkg::opCallR, 8, 0, 0));
    emitMove(9, 32'h55); // Runs after return
    emitStore(32'h210, 9);
    emitStore(32'h214, 0);
    put(enc(isaPkg::opHalt, 0, 0, 0));
    pc = 32'h100; // Subroutine
    emitMove(10, 32'hab);
    emitStore(32'h20c, 10);
    put(enc(isaPkg::opRet, 0, 0, 0));
    runProgram();
    check("pop first", 33, readWord(32'h200));
    check("pop second", 22, readWord(32'h204));
    check("pop third", 11, readWord(32'h208));
    check("marker", 32'hab, readWord(32'h20c));
    check("after call", 32'h55, readWord(32'h210));
    check("sp restored", 32'h380, readWord(32'h214));
  endtask

  task automatic haltTest();
    beginProgram("halt");
    emitMove(2, 32'h1234);
    emitStore(32'h200, 2);
    put(32'h0000_003f); // Not an opcode
    emitMove(3, 9);
    emitStore(32'h204, 3);
    put(enc(isaPkg::opHalt, 0, 0, 0));
    runProgram();
    check("before unknown", 32'h1234, readWord(32'h200));
    check("after unknown", 0, readWord(32'h204));
    repeat (50) begin
      @(negedge clk);
      check("halted held", 1, memPkg::wordT'(halted));
      check("valid after halt", 0, memPkg::wordT'(memReqValid));
    end
    check("assertion failures", 0, memPkg::wordT'(u_dut.u_asserts.failCount));
  endtask

  initial begin
    for (int round = 0; round < 2; round++) begin
      @(posedge clk);
      stallEnable <= (round == 1); // Second round under back-pressure
      @(posedge clk);
      arithTest();
      branchTest();
      memoryTest();
      stackTest();
    end
    haltTest();
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+.
memPkg.sv
isaPkg.sv
instrDecode.sv
regFile.sv
execUnit.sv
memAccess.sv
coreSequencer.sv
coreTop.sv
core_assertions.sv
tbMemory.sv
tbCore.sv
